//--- src/fetch_queue_pkg.sv
package fetch_queue_pkg;

    // four instructions per bundle, one decoder per bundle slot
    parameter int ISSUE_WIDTH = 4;
    parameter int INSN_WIDTH  = 32;

    // one fixed-size instruction word
    typedef logic [INSN_WIDTH-1:0] insn_t;

    // a fetch bundle, slot 0 holds the oldest instruction
    typedef insn_t [ISSUE_WIDTH-1:0] bundle_t;

    // selects one of the decoders, or one bundle slot
    typedef logic [$clog2(ISSUE_WIDTH)-1:0] decoder_idx_t;

    // one bit per decoder
    typedef logic [ISSUE_WIDTH-1:0] decoder_mask_t;

    // 0 up to ISSUE_WIDTH instructions moved in a cycle
    typedef logic [2:0] issue_cnt_t;

    // what a single decoder receives
    typedef struct packed {
        logic  valid;   // slot carries an instruction this cycle
        insn_t insn;
    } dispatch_slot_t;

    // indexed by decoder number
    typedef dispatch_slot_t [ISSUE_WIDTH-1:0] dispatch_vec_t;

endpackage

//--- src/insn_queue.sv
`timescale 1ns/100ps

module insn_queue #(
    parameter int QUEUE_DEPTH_LOG2 = 5
) (
    input  logic                        clock_i,
    input  logic                        reset_i,
    input  logic                        bundle_valid_i,
    input  fetch_queue_pkg::bundle_t    bundle_i,
    input  fetch_queue_pkg::issue_cnt_t pop_cnt_i,
    output fetch_queue_pkg::bundle_t    head_insns_o,
    output logic [QUEUE_DEPTH_LOG2:0]   count_o,
    output logic                        full_o,
    output logic                        empty_o
);
    import fetch_queue_pkg::*;

    localparam int DEPTH      = 2 ** QUEUE_DEPTH_LOG2;
    localparam int FULL_LEVEL = DEPTH - ISSUE_WIDTH;   // above this a bundle no longer fits

    typedef logic [QUEUE_DEPTH_LOG2-1:0] ptr_t;
    typedef logic [QUEUE_DEPTH_LOG2:0]   count_t;

    insn_t  mem [DEPTH];
    ptr_t   head_q;                                   // oldest entry
    ptr_t   tail_q;                                   // next free entry
    count_t count_q;
    count_t count_next;
    logic   full_q;
    logic   empty_q;
    logic   accept;

    // a bundle offered while full is dropped, the source has to retry
    assign accept = bundle_valid_i && !full_q;

    // pop never exceeds the occupancy, so subtracting first cannot wrap
    always_comb
    begin
        count_next = count_q - count_t'(pop_cnt_i);
        if (accept)
        begin
            count_next = count_next + count_t'(ISSUE_WIDTH);
        end
    end

    // whole bundle lands at the tail, slot 0 first
    always_ff @(posedge clock_i)
    begin
        if (accept)
        begin
            for (int i = 0; i < ISSUE_WIDTH; i++)
            begin
                mem[tail_q + ptr_t'(i)] <= bundle_i[i];   // pointer wraps naturally
            end
        end
    end

    always_ff @(posedge clock_i)
    begin
        if (reset_i)
        begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            full_q  <= 1'b0;
            empty_q <= 1'b1;
        end
        else
        begin
            head_q <= head_q + ptr_t'(pop_cnt_i);
            if (accept)
            begin
                tail_q <= tail_q + ptr_t'(ISSUE_WIDTH);
            end
            count_q <= count_next;
            full_q  <= (count_next > count_t'(FULL_LEVEL));   // flags track the new count
            empty_q <= (count_next == '0);
        end
    end

    // oldest entries, head first; slots past the count hold stale data
    always_comb
    begin
        for (int i = 0; i < ISSUE_WIDTH; i++)
        begin
            head_insns_o[i] = mem[head_q + ptr_t'(i)];
        end
    end

    assign count_o = count_q;
    assign full_o  = full_q;
    assign empty_o = empty_q;

endmodule

//--- src/dispatch_steer.sv
`timescale 1ns/100ps

module dispatch_steer (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  fetch_queue_pkg::decoder_mask_t decoder_busy_i,
    input  fetch_queue_pkg::bundle_t       head_insns_i,
    input  fetch_queue_pkg::issue_cnt_t    count_i,
    output fetch_queue_pkg::issue_cnt_t    pop_cnt_o,
    output fetch_queue_pkg::dispatch_vec_t dispatch_o
);
    import fetch_queue_pkg::*;

    decoder_idx_t  rank [ISSUE_WIDTH];   // free decoders below each decoder
    issue_cnt_t    free_cnt;
    issue_cnt_t    issue_cnt;
    decoder_mask_t valid_next;
    bundle_t       insn_next;
    decoder_mask_t valid_q;
    bundle_t       insn_q;

    // rank the free decoders by index
    // a free decoder's rank is the age of the instruction it would take
    always_comb
    begin
        free_cnt = '0;
        for (int d = 0; d < ISSUE_WIDTH; d++)
        begin
            rank[d] = decoder_idx_t'(free_cnt);   // at most ISSUE_WIDTH-1 here
            if (!decoder_busy_i[d])
            begin
                free_cnt = free_cnt + issue_cnt_t'(1);
            end
        end
    end

    // issue the smaller of free decoders and held instructions
    assign issue_cnt = (free_cnt < count_i) ? free_cnt : count_i;
    assign pop_cnt_o = issue_cnt;

    // k-th oldest instruction to the k-th free decoder
    always_comb
    begin
        for (int d = 0; d < ISSUE_WIDTH; d++)
        begin
            valid_next[d] = !decoder_busy_i[d] && (issue_cnt_t'(rank[d]) < issue_cnt);
            insn_next[d]  = head_insns_i[rank[d]];
        end
    end

    // decoders that got nothing see a low valid next cycle
    always_ff @(posedge clock_i)
    begin
        if (reset_i)
        begin
            valid_q <= '0;
        end
        else
        begin
            valid_q <= valid_next;
        end
    end

    // payload only loads where an instruction was handed out
    always_ff @(posedge clock_i)
    begin
        for (int d = 0; d < ISSUE_WIDTH; d++)
        begin
            if (valid_next[d])
            begin
                insn_q[d] <= insn_next[d];
            end
        end
    end

    always_comb
    begin
        for (int d = 0; d < ISSUE_WIDTH; d++)
        begin
            dispatch_o[d].valid = valid_q[d];
            dispatch_o[d].insn  = insn_q[d];
        end
    end

endmodule

//--- src/fetch_queue_top.sv
`timescale 1ns/100ps

module fetch_queue_top #(
    parameter int QUEUE_DEPTH_LOG2 = 5
) (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  logic                           bundle_valid_i,
    input  fetch_queue_pkg::bundle_t       bundle_i,
    input  fetch_queue_pkg::decoder_mask_t decoder_busy_i,
    output fetch_queue_pkg::dispatch_vec_t dispatch_o,
    output logic                           full_o,
    output logic                           empty_o
);
    import fetch_queue_pkg::*;

    typedef logic [QUEUE_DEPTH_LOG2:0] count_t;

    bundle_t    head_insns;
    count_t     queue_count;
    issue_cnt_t steer_count;   // occupancy clamped to one bundle
    issue_cnt_t pop_cnt;

    // steering never needs more than ISSUE_WIDTH, so it stays depth independent
    assign steer_count = (queue_count > count_t'(ISSUE_WIDTH)) ? issue_cnt_t'(ISSUE_WIDTH)
                                                               : issue_cnt_t'(queue_count);

    insn_queue #(
        .QUEUE_DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) u_insn_queue (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .bundle_valid_i (bundle_valid_i),
        .bundle_i       (bundle_i),
        .pop_cnt_i      (pop_cnt),
        .head_insns_o   (head_insns),
        .count_o        (queue_count),
        .full_o         (full_o),
        .empty_o        (empty_o)
    );

    dispatch_steer u_dispatch_steer (
        .clock_i        (clock_i),
        .reset_i        (reset_i),
        .decoder_busy_i (decoder_busy_i),
        .head_insns_i   (head_insns),
        .count_i        (steer_count),
        .pop_cnt_o      (pop_cnt),
        .dispatch_o     (dispatch_o)
    );

endmodule

//--- dv/fetch_queue_checker.sv
`timescale 1ns/100ps

module fetch_queue_checker #(
    parameter int QUEUE_DEPTH_LOG2 = 5
) (
    input  logic                           clock_i,
    input  logic                           reset_i,
    input  logic                           bundle_valid_i,
    input  fetch_queue_pkg::bundle_t       bundle_i,
    input  fetch_queue_pkg::decoder_mask_t decoder_busy_i,
    input  fetch_queue_pkg::dispatch_vec_t dispatch_i,
    input  logic                           full_i,
    input  logic                           empty_i,
    output int                             error_cnt_o,
    output int                             check_cnt_o,
    output int                             pending_o
);
    import fetch_queue_pkg::*;

    localparam int DEPTH = 2 ** QUEUE_DEPTH_LOG2;

    insn_t         expected_q [$];   // accepted words, oldest first
    int            model_count = 0;
    int            prev_count  = 0;  // occupancy when the shown dispatch was decided
    decoder_mask_t prev_busy   = '1;
    int            error_cnt   = 0;
    int            check_cnt   = 0;

    function automatic int count_free(decoder_mask_t busy);
        int n;
        n = 0;
        for (int d = 0; d < ISSUE_WIDTH; d++)
        begin
            if (!busy[d])
            begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int min_int(int a, int b);
        return (a < b) ? a : b;
    endfunction

    task automatic report_value(string name, logic [31:0] expected, logic [31:0] actual);
        error_cnt++;
        $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
    endtask

    task automatic report_text(string text);
        error_cnt++;
        $display("[ERROR] %0t %s", $time, text);
    endtask

    always @(posedge clock_i)
    begin
        int    issued;
        int    pop_now;
        logic  accept;
        insn_t word;
        if (reset_i)
        begin
            expected_q.delete();
            model_count = 0;
            prev_count  = 0;
            prev_busy   = '1;
        end
        else
        begin
            check_cnt = check_cnt + 3;
            assert (full_i == (model_count > DEPTH - ISSUE_WIDTH))
            else report_value("full_o", 32'(model_count > DEPTH - ISSUE_WIDTH), 32'(full_i));
            assert (empty_i == (model_count == 0))
            else report_value("empty_o", 32'(model_count == 0), 32'(empty_i));
            issued = 0;
            // valid slots read from decoder 0 upward follow program order
            for (int d = 0; d < ISSUE_WIDTH; d++)
            begin
                if (dispatch_i[d].valid)
                begin
                    issued++;
                    check_cnt = check_cnt + 2;
                    assert (!prev_busy[d])
                    else report_text($sformatf("decoder %0d got an instruction while busy", d));
                    if (expected_q.size() == 0)
                    begin
                        report_text($sformatf("decoder %0d got a word never accepted", d));
                    end
                    else
                    begin
                        word = expected_q.pop_front();
                        assert (dispatch_i[d].insn == word)
                        else report_value($sformatf("dispatch_o[%0d].insn", d), word,
                                          dispatch_i[d].insn);
                    end
                end
            end
            assert (issued == min_int(count_free(prev_busy), prev_count))
            else report_value("dispatch_o valid count",
                              32'(min_int(count_free(prev_busy), prev_count)), 32'(issued));

            // decision of this cycle, shown after the next edge
            pop_now     = min_int(count_free(decoder_busy_i), model_count);
            accept      = bundle_valid_i && (model_count <= DEPTH - ISSUE_WIDTH);
            prev_count  = model_count;
            prev_busy   = decoder_busy_i;
            model_count = model_count - pop_now + (accept ? ISSUE_WIDTH : 0);
            if (accept)
            begin
                for (int i = 0; i < ISSUE_WIDTH; i++)
                begin
                    expected_q.push_back(bundle_i[i]);
                end
            end
        end
        pending_o = expected_q.size();
    end

    assign error_cnt_o = error_cnt;
    assign check_cnt_o = check_cnt;

endmodule

//--- dv/fetch_queue_tb.sv
`timescale 1ns/100ps

module fetch_queue_tb;
    import fetch_queue_pkg::*;

    localparam int QUEUE_DEPTH_LOG2 = 5;

    logic          clock = 1'b0;
    logic          reset;
    logic          bundle_valid;
    bundle_t       bundle;
    decoder_mask_t decoder_busy;
    dispatch_vec_t dispatch;
    logic          full;
    logic          empty;
    int            error_cnt;
    int            check_cnt;
    int            pending;
    int            fail_cnt;       // timeouts and leftovers
    int            seq;            // running sequence number in every word
    int            wait_cycles;

    always #2 clock = ~clock;

    fetch_queue_top #(
        .QUEUE_DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) DUT (
        .clock_i        (clock),
        .reset_i        (reset),
        .bundle_valid_i (bundle_valid),
        .bundle_i       (bundle),
        .decoder_busy_i (decoder_busy),
        .dispatch_o     (dispatch),
        .full_o         (full),
        .empty_o        (empty)
    );

    fetch_queue_checker #(
        .QUEUE_DEPTH_LOG2 (QUEUE_DEPTH_LOG2)
    ) u_checker (
        .clock_i        (clock),
        .reset_i        (reset),
        .bundle_valid_i (bundle_valid),
        .bundle_i       (bundle),
        .decoder_busy_i (decoder_busy),
        .dispatch_i     (dispatch),
        .full_i         (full),
        .empty_i        (empty),
        .error_cnt_o    (error_cnt),
        .check_cnt_o    (check_cnt),
        .pending_o      (pending)
    );

    task automatic drive_cycle(logic valid, decoder_mask_t busy);
        bundle_t next_bundle;
        @(posedge clock);
        for (int i = 0; i < ISSUE_WIDTH; i++)
        begin
            next_bundle[i] = {8'h5a, 24'(seq + i)};   // tag plus sequence number
        end
        seq = seq + ISSUE_WIDTH;
        bundle_valid <= valid;
        decoder_busy <= busy;
        bundle       <= next_bundle;
    endtask

    initial
    begin
        void'($urandom(32'hd6a6));
        reset        = 1'b1;
        bundle_valid = 1'b0;
        bundle       = '0;
        decoder_busy = '1;
        seq          = 0;
        fail_cnt     = 0;
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        // decoders stalled, fill up
        wait_cycles = 0;
        while (!full && wait_cycles < 64)
        begin
            drive_cycle(1'b1, '1);
            wait_cycles++;
        end
        if (!full)
        begin
            $display("timeout: queue never reported full with all decoders busy");
            fail_cnt++;
        end
        repeat (6) drive_cycle(1'b1, '1);   // these offers are dropped

        repeat (400) drive_cycle(1'($urandom), decoder_mask_t'($urandom));

        // drain with every decoder free
        wait_cycles = 0;
        drive_cycle(1'b0, '0);
        while (!empty && wait_cycles < 64)
        begin
            drive_cycle(1'b0, '0);
            wait_cycles++;
        end
        if (!empty)
        begin
            $display("timeout: queue never returned to empty while draining");
            fail_cnt++;
        end
        repeat (3) drive_cycle(1'b0, '0);   // last dispatch leaves the output register
        @(negedge clock);
        if (pending != 0)
        begin
            $display("%0d accepted instructions were never dispatched", pending);
            fail_cnt++;
        end

        $display("checks: %0d  errors: %0d  other failures: %0d", check_cnt, error_cnt, fail_cnt);
        if (error_cnt == 0 && fail_cnt == 0)
        begin
            $display("STATUS: PASS");
        end
        else
        begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- flist.f
src/fetch_queue_pkg.sv
src/insn_queue.sv
src/dispatch_steer.sv
src/fetch_queue_top.sv
dv/fetch_queue_checker.sv
dv/fetch_queue_tb.sv

//--- run.sh
#!/bin/sh
# build and run the fetch queue testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
    --timescale 1ns/100ps \
    -f flist.f \
    --top-module fetch_queue_tb \
    -o fetch_queue_sim

./obj_dir/fetch_queue_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi
